// ==== armCtrl_config.svh ====
`ifndef ARM_CTRL_CONFIG_SVH
`define ARM_CTRL_CONFIG_SVH

`define WORD_W    32   // Instruction and data width

// Multi-bit instruction fields
`define COND_MSB  31
`define COND_LSB  28
`define CLASS_MSB 27
`define CLASS_LSB 26
`define OPC_MSB   24
`define OPC_LSB   21
`define RD_MSB    15
`define RD_LSB    12

// Single control bits
`define IMM_BIT   25   // Immediate operand 2
`define UP_BIT    23   // Add offset when set
`define BYTE_BIT  22   // Byte access
`define LOAD_BIT  20   // Load when set
`define SBIT      20   // Shares bit 20 with LOAD_BIT

`define PC_REG    15   // R15 is the program counter

`define NOP_INSTR 32'hF000_0000  // NV condition so it never executes

`endif

// ==== armIsaPkg.sv ====
package armIsaPkg;

  // Class field of the instruction word
  typedef enum logic [1:0] {
    dataProc   = 2'b00,
    loadStore  = 2'b01,
    branch     = 2'b10,
    undefClass = 2'b11    // Treated as a no-op
  } instrClass_e;

  // Data-processing opcodes in encoding order
  typedef enum logic [3:0] {
    opAnd, opEor, opSub, opRsb,   // 0x0 to 0x3
    opAdd, opAdc, opSbc, opRsc,   // 0x4 to 0x7
    opTst, opTeq, opCmp, opCmn,   // Compares write no register
    opOrr, opMov, opBic, opMvn    // 0xC to 0xF
  } aluOp_e;

  // Condition codes
  typedef enum logic [3:0] {
    condEq, condNe, condCs, condCc,
    condMi, condPl, condVs, condVc,
    condHi, condLs, condGe, condLt,
    condGt, condLe, condAl, condNv   // NV never executes
  } cond_e;

  typedef struct packed {
    logic n;   // Negative
    logic z;   // Zero
    logic c;   // Carry
    logic v;   // Overflow
  } nzcv_t;

  // Which flag bits an instruction updates
  typedef enum logic [1:0] {
    noFlags  = 2'b00,
    nzOnly   = 2'b01,   // Logical ops keep C and V
    allFlags = 2'b10
  } flagWrite_e;

endpackage

// ==== armPipePkg.sv ====
package armPipePkg;

  // Register read source selects
  typedef logic [1:0] regSrc_t;

  localparam int RegSrcPcBit = 0;   // Branch reads PC as Rn
  localparam int RegSrcRdBit = 1;   // Store reads Rd as second operand

  // Immediate extension format
  typedef enum logic [1:0] {
    imm8Rot = 2'b00,   // Data processing rotated imm8
    imm12   = 2'b01,   // Load/store offset
    imm24   = 2'b10    // Branch offset
  } immSrc_e;

  // One enable per byte lane of the data word
  typedef logic [3:0] byteMask_t;

  localparam byteMask_t WordMask = 4'b1111;   // Word access uses all lanes

endpackage

// ==== instrDecoder.sv ====
`include "armCtrl_config.svh"

module instrDecoder (
  input  logic [`WORD_W-1:0]    instrD,
  output armPipePkg::regSrc_t   regSrcD,
  output armPipePkg::immSrc_e   immSrcD,
  output logic                  aluSrcD,
  output logic                  memtoRegD,
  output logic                  regWriteD,
  output logic                  memWriteD,
  output logic                  branchD,
  output logic                  pcSrcD,
  output logic                  byteD,
  output armIsaPkg::aluOp_e     aluControlD,
  output armIsaPkg::flagWrite_e flagWriteD
);

  armIsaPkg::instrClass_e instrClass;
  armIsaPkg::aluOp_e      opcode;
  logic                   isCompare;   // TST TEQ CMP CMN
  logic                   isArith;     // Opcodes that produce C and V
  logic                   isLoad;

  assign instrClass = armIsaPkg::instrClass_e'(instrD[`CLASS_MSB:`CLASS_LSB]);
  assign opcode     = armIsaPkg::aluOp_e'(instrD[`OPC_MSB:`OPC_LSB]);
  assign isLoad     = instrD[`LOAD_BIT];

  assign isCompare = opcode inside {armIsaPkg::opTst, armIsaPkg::opTeq,
                                    armIsaPkg::opCmp, armIsaPkg::opCmn};
  assign isArith   = opcode inside {armIsaPkg::opSub, armIsaPkg::opRsb, armIsaPkg::opAdd,
                                    armIsaPkg::opAdc, armIsaPkg::opSbc, armIsaPkg::opRsc,
                                    armIsaPkg::opCmp, armIsaPkg::opCmn};

  // ======================================
  // Main decoder
  // ======================================
  always_comb begin
    regSrcD     = '0;                    // Defaults are the no-op
    immSrcD     = armPipePkg::imm8Rot;
    aluSrcD     = 1'b0;
    memtoRegD   = 1'b0;
    regWriteD   = 1'b0;
    memWriteD   = 1'b0;
    branchD     = 1'b0;
    byteD       = 1'b0;
    aluControlD = armIsaPkg::opAdd;
    flagWriteD  = armIsaPkg::noFlags;
    case (instrClass)
      armIsaPkg::dataProc: begin
        aluSrcD     = instrD[`IMM_BIT];   // Immediate or register operand 2
        regWriteD   = ~isCompare;
        aluControlD = opcode;             // Opcode passes straight to the ALU
        if (instrD[`SBIT]) begin
          flagWriteD = isArith ? armIsaPkg::allFlags : armIsaPkg::nzOnly;
        end
      end
      armIsaPkg::loadStore: begin
        immSrcD     = armPipePkg::imm12;
        aluSrcD     = 1'b1;               // Base plus offset
        memtoRegD   = isLoad;
        regWriteD   = isLoad;
        memWriteD   = ~isLoad;
        byteD       = instrD[`BYTE_BIT];
        aluControlD = instrD[`UP_BIT] ? armIsaPkg::opAdd : armIsaPkg::opSub;
        regSrcD[armPipePkg::RegSrcRdBit] = ~isLoad;   // Store data comes from Rd
      end
      armIsaPkg::branch: begin
        immSrcD = armPipePkg::imm24;
        aluSrcD = 1'b1;                   // PC plus offset
        branchD = 1'b1;
        regSrcD[armPipePkg::RegSrcPcBit] = 1'b1;
      end
      default: ;                          // undefClass keeps the no-op
    endcase
  end

  // Branch, or any register write that lands in R15
  assign pcSrcD = branchD | (regWriteD & (instrD[`RD_MSB:`RD_LSB] == 4'(`PC_REG)));

endmodule

// ==== condUnit.sv ====
module condUnit (
  input  armIsaPkg::cond_e      condE,
  input  armIsaPkg::nzcv_t      flagsE,       // Forwarded flags
  input  armIsaPkg::nzcv_t      aluFlagsE,
  input  armIsaPkg::flagWrite_e flagWriteE,
  output logic                  condEx,
  output armIsaPkg::nzcv_t      flagsNextE
);

  logic geFlag;   // Signed greater or equal

  assign geFlag = (flagsE.n == flagsE.v);

  // Condition check
  always_comb begin
    case (condE)
      armIsaPkg::condEq: condEx = flagsE.z;
      armIsaPkg::condNe: condEx = ~flagsE.z;
      armIsaPkg::condCs: condEx = flagsE.c;
      armIsaPkg::condCc: condEx = ~flagsE.c;
      armIsaPkg::condMi: condEx = flagsE.n;
      armIsaPkg::condPl: condEx = ~flagsE.n;
      armIsaPkg::condVs: condEx = flagsE.v;
      armIsaPkg::condVc: condEx = ~flagsE.v;
      armIsaPkg::condHi: condEx = flagsE.c & ~flagsE.z;    // Unsigned higher
      armIsaPkg::condLs: condEx = ~flagsE.c | flagsE.z;
      armIsaPkg::condGe: condEx = geFlag;
      armIsaPkg::condLt: condEx = ~geFlag;
      armIsaPkg::condGt: condEx = ~flagsE.z & geFlag;
      armIsaPkg::condLe: condEx = flagsE.z | ~geFlag;
      armIsaPkg::condAl: condEx = 1'b1;
      default:           condEx = 1'b0;                    // NV
    endcase
  end

  // Next flags merge ALU result into the forwarded flags
  always_comb begin
    flagsNextE = flagsE;
    if (flagWriteE != armIsaPkg::noFlags) begin
      flagsNextE.n = aluFlagsE.n;
      flagsNextE.z = aluFlagsE.z;
    end
    if (flagWriteE == armIsaPkg::allFlags) begin   // Arithmetic only
      flagsNextE.c = aluFlagsE.c;
      flagsNextE.v = aluFlagsE.v;
    end
  end

endmodule

// ==== statusFlags.sv ====
module statusFlags (
  input  logic             clk,
  input  logic             rst,
  input  logic             stallW,
  input  armIsaPkg::nzcv_t flagsNextM,
  input  logic             setFlagsM,
  input  armIsaPkg::nzcv_t flagsNextW,
  input  logic             setFlagsW,
  output armIsaPkg::nzcv_t flagsE,
  output armIsaPkg::nzcv_t flagsW
);

  // NZCV register, written as the instruction leaves Writeback
  always_ff @(posedge clk) begin
    if (rst) begin
      flagsW <= '0;
    end else if (~stallW & setFlagsW) begin
      flagsW <= flagsNextW;
    end
  end

  // Forwarding to Execute, youngest producer first
  always_comb begin
    if (setFlagsM) begin
      flagsE = flagsNextM;
    end else if (setFlagsW) begin
      flagsE = flagsNextW;
    end else begin
      flagsE = flagsW;   // No flag setter in flight
    end
  end

endmodule

// ==== pipeCtrl.sv ====
`include "armCtrl_config.svh"

module pipeCtrl (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  stallE,
  input  logic                  stallM,
  input  logic                  stallW,
  input  logic                  flushE,
  input  logic                  flushW,
  input  logic                  aluSrcD,
  input  logic                  memtoRegD,
  input  logic                  regWriteD,
  input  logic                  memWriteD,
  input  logic                  branchD,
  input  logic                  pcSrcD,
  input  logic                  byteD,
  input  armIsaPkg::aluOp_e     aluControlD,
  input  armIsaPkg::flagWrite_e flagWriteD,
  input  armIsaPkg::cond_e      condD,
  input  logic [1:0]            addrLowE,     // Low bits of the ALU result
  input  logic                  condEx,
  input  armIsaPkg::nzcv_t      flagsNextE,
  output armIsaPkg::cond_e      condE,
  output armIsaPkg::flagWrite_e flagWriteE,
  output armIsaPkg::nzcv_t      flagsNextM,
  output armIsaPkg::nzcv_t      flagsNextW,
  output logic                  setFlagsM,
  output logic                  setFlagsW,
  output logic                  aluSrcE,
  output armIsaPkg::aluOp_e     aluControlE,
  output logic                  branchTakenE,
  output logic                  memWriteM,
  output logic                  memtoRegM,
  output logic                  regWriteM,
  output armPipePkg::byteMask_t byteMaskM,
  output logic                  regWriteW,
  output logic                  memtoRegW,
  output logic                  pcSrcW,
  output logic                  loadByteW,    // Load length select
  output logic [1:0]            byteOffsetW
);

  localparam logic [`WORD_W-1:0] NopInstr   = `NOP_INSTR;
  localparam armIsaPkg::cond_e   BubbleCond =
    armIsaPkg::cond_e'(NopInstr[`COND_MSB:`COND_LSB]);   // Bubbles never execute

  logic                  memtoRegE, regWriteE, memWriteE, branchE, pcSrcE, byteE;
  logic                  regWriteGatedE, memWriteGatedE, pcSrcGatedE, setFlagsE;
  armPipePkg::byteMask_t byteMaskE;
  logic                  pcSrcM, byteM;
  logic [1:0]            byteOffsetM;

  // ======================================
  // Execute stage
  // ======================================
  always_ff @(posedge clk) begin
    if (rst | flushE) begin           // Flush wins over stall
      condE       <= BubbleCond;
      flagWriteE  <= armIsaPkg::noFlags;
      aluControlE <= armIsaPkg::opAnd;
      aluSrcE     <= 1'b0;
      memtoRegE   <= 1'b0;
      regWriteE   <= 1'b0;
      memWriteE   <= 1'b0;
      branchE     <= 1'b0;
      pcSrcE      <= 1'b0;
      byteE       <= 1'b0;
    end else if (~stallE) begin
      condE       <= condD;
      flagWriteE  <= flagWriteD;
      aluControlE <= aluControlD;
      aluSrcE     <= aluSrcD;
      memtoRegE   <= memtoRegD;
      regWriteE   <= regWriteD;
      memWriteE   <= memWriteD;
      branchE     <= branchD;
      pcSrcE      <= pcSrcD;
      byteE       <= byteD;
    end
  end

  // Condition gating of every architectural write
  assign regWriteGatedE = regWriteE & condEx;
  assign memWriteGatedE = memWriteE & condEx;
  assign pcSrcGatedE    = pcSrcE & condEx;
  assign branchTakenE   = branchE & condEx;
  assign setFlagsE      = (flagWriteE != armIsaPkg::noFlags) & condEx;

  // Byte access enables the addressed lane only
  assign byteMaskE = byteE ? (4'b0001 << addrLowE) : armPipePkg::WordMask;

  // ======================================
  // Memory stage
  // ======================================
  always_ff @(posedge clk) begin
    if (rst) begin                    // No flush here
      memWriteM   <= 1'b0;
      memtoRegM   <= 1'b0;
      regWriteM   <= 1'b0;
      pcSrcM      <= 1'b0;
      setFlagsM   <= 1'b0;
      flagsNextM  <= '0;
      byteMaskM   <= '0;
      byteM       <= 1'b0;
      byteOffsetM <= 2'b00;
    end else if (~stallM) begin
      memWriteM   <= memWriteGatedE;
      memtoRegM   <= memtoRegE;
      regWriteM   <= regWriteGatedE;
      pcSrcM      <= pcSrcGatedE;
      setFlagsM   <= setFlagsE;
      flagsNextM  <= flagsNextE;
      byteMaskM   <= byteMaskE;
      byteM       <= byteE;
      byteOffsetM <= addrLowE;        // Lane for load alignment
    end
  end

  // ======================================
  // Writeback stage
  // ======================================
  always_ff @(posedge clk) begin
    if (rst | flushW) begin
      regWriteW   <= 1'b0;
      memtoRegW   <= 1'b0;
      pcSrcW      <= 1'b0;
      setFlagsW   <= 1'b0;
      flagsNextW  <= '0;
      loadByteW   <= 1'b0;
      byteOffsetW <= 2'b00;
    end else if (~stallW) begin
      regWriteW   <= regWriteM;
      memtoRegW   <= memtoRegM;
      pcSrcW      <= pcSrcM;
      setFlagsW   <= setFlagsM;
      flagsNextW  <= flagsNextM;
      loadByteW   <= byteM;
      byteOffsetW <= byteOffsetM;
    end
  end

endmodule

// ==== armController.sv ====
`include "armCtrl_config.svh"

module armController (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`WORD_W-1:0]    instrD,
  input  armIsaPkg::nzcv_t      aluFlagsE,
  input  logic [1:0]            addrLowE,
  input  logic                  stallE,
  input  logic                  stallM,
  input  logic                  stallW,
  input  logic                  flushE,
  input  logic                  flushW,
  output armPipePkg::regSrc_t   regSrcD,
  output armPipePkg::immSrc_e   immSrcD,
  output logic                  aluSrcE,
  output armIsaPkg::aluOp_e     aluControlE,
  output logic                  branchTakenE,
  output logic                  memWriteM,
  output logic                  memtoRegM,
  output logic                  regWriteM,
  output armPipePkg::byteMask_t byteMaskM,
  output logic                  regWriteW,
  output logic                  memtoRegW,
  output logic                  pcSrcW,
  output logic                  loadByteW,
  output logic [1:0]            byteOffsetW,
  output armIsaPkg::nzcv_t      flagsW
);

  // Decode controls
  logic                  aluSrcD, memtoRegD, regWriteD, memWriteD, branchD, pcSrcD, byteD;
  armIsaPkg::aluOp_e     aluControlD;
  armIsaPkg::flagWrite_e flagWriteD;
  armIsaPkg::cond_e      condD;
  // Execute condition path
  armIsaPkg::cond_e      condE;
  armIsaPkg::flagWrite_e flagWriteE;
  armIsaPkg::nzcv_t      flagsE, flagsNextE;
  logic                  condEx;
  // Flag pipeline
  armIsaPkg::nzcv_t      flagsNextM, flagsNextW;
  logic                  setFlagsM, setFlagsW;

  assign condD = armIsaPkg::cond_e'(instrD[`COND_MSB:`COND_LSB]);

  instrDecoder decoder (
    .instrD(instrD), .regSrcD(regSrcD), .immSrcD(immSrcD), .aluSrcD(aluSrcD),
    .memtoRegD(memtoRegD), .regWriteD(regWriteD), .memWriteD(memWriteD),
    .branchD(branchD), .pcSrcD(pcSrcD), .byteD(byteD),
    .aluControlD(aluControlD), .flagWriteD(flagWriteD)
  );

  pipeCtrl pipe (
    .clk(clk), .rst(rst), .stallE(stallE), .stallM(stallM), .stallW(stallW),
    .flushE(flushE), .flushW(flushW), .aluSrcD(aluSrcD), .memtoRegD(memtoRegD),
    .regWriteD(regWriteD), .memWriteD(memWriteD), .branchD(branchD), .pcSrcD(pcSrcD),
    .byteD(byteD), .aluControlD(aluControlD), .flagWriteD(flagWriteD), .condD(condD),
    .addrLowE(addrLowE), .condEx(condEx), .flagsNextE(flagsNextE), .condE(condE),
    .flagWriteE(flagWriteE), .flagsNextM(flagsNextM), .flagsNextW(flagsNextW),
    .setFlagsM(setFlagsM), .setFlagsW(setFlagsW), .aluSrcE(aluSrcE),
    .aluControlE(aluControlE), .branchTakenE(branchTakenE), .memWriteM(memWriteM),
    .memtoRegM(memtoRegM), .regWriteM(regWriteM), .byteMaskM(byteMaskM),
    .regWriteW(regWriteW), .memtoRegW(memtoRegW), .pcSrcW(pcSrcW),
    .loadByteW(loadByteW), .byteOffsetW(byteOffsetW)
  );

  condUnit cond (
    .condE(condE), .flagsE(flagsE), .aluFlagsE(aluFlagsE), .flagWriteE(flagWriteE),
    .condEx(condEx), .flagsNextE(flagsNextE)
  );

  statusFlags flags (
    .clk(clk), .rst(rst), .stallW(stallW), .flagsNextM(flagsNextM),
    .setFlagsM(setFlagsM), .flagsNextW(flagsNextW), .setFlagsW(setFlagsW),
    .flagsE(flagsE), .flagsW(flagsW)
  );

endmodule

// ==== tbArmController.sv ====
`include "armCtrl_config.svh"

module tbArmController;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NumInstr   = 2000;
  localparam int CycleLimit = NumInstr * 2 + 20;   // Room for stalls and drain

  logic                  clk, rst;
  logic [`WORD_W-1:0]    instrD;
  armIsaPkg::nzcv_t      aluFlagsE;
  logic [1:0]            addrLowE;
  logic                  stallE, stallM, stallW, flushE, flushW;
  armPipePkg::regSrc_t   regSrcD;
  armPipePkg::immSrc_e   immSrcD;
  logic                  aluSrcE, branchTakenE, memWriteM, memtoRegM, regWriteM;
  armIsaPkg::aluOp_e     aluControlE;
  armPipePkg::byteMask_t byteMaskM;
  logic                  regWriteW, memtoRegW, pcSrcW, loadByteW;
  logic [1:0]            byteOffsetW;
  armIsaPkg::nzcv_t      flagsW;

  integer seed = 72449;
  int     cycleCount = 0;

  // Decode of the instruction now on instrD
  logic                  dAluSrc, dMemtoReg, dRegWrite, dMemWrite, dBranch, dPcSrc, dByte;
  armIsaPkg::aluOp_e     dAluOp;
  armIsaPkg::flagWrite_e dFlagWrite;
  armIsaPkg::cond_e      dCond;
  armPipePkg::regSrc_t   dRegSrc;
  armPipePkg::immSrc_e   dImmSrc;
  // Shadow pipeline
  armIsaPkg::cond_e      mCondE;
  armIsaPkg::flagWrite_e mFlagWriteE;
  armIsaPkg::aluOp_e     mAluOpE;
  logic                  mAluSrcE, mMemtoRegE, mRegWriteE, mMemWriteE, mBranchE, mPcSrcE, mByteE;
  logic                  mMemWriteM, mMemtoRegM, mRegWriteM, mPcSrcM, mSetFlagsM, mByteM;
  armIsaPkg::nzcv_t      mFlagsNextM, mFlagsNextW, mFlags;
  armPipePkg::byteMask_t mByteMaskM;
  logic [1:0]            mOffsetM, mOffsetW;
  logic                  mRegWriteW, mMemtoRegW, mPcSrcW, mSetFlagsW, mLoadByteW;

  armController uut (
    .clk(clk), .rst(rst), .instrD(instrD), .aluFlagsE(aluFlagsE), .addrLowE(addrLowE),
    .stallE(stallE), .stallM(stallM), .stallW(stallW), .flushE(flushE), .flushW(flushW),
    .regSrcD(regSrcD), .immSrcD(immSrcD), .aluSrcE(aluSrcE), .aluControlE(aluControlE),
    .branchTakenE(branchTakenE), .memWriteM(memWriteM), .memtoRegM(memtoRegM),
    .regWriteM(regWriteM), .byteMaskM(byteMaskM), .regWriteW(regWriteW),
    .memtoRegW(memtoRegW), .pcSrcW(pcSrcW), .loadByteW(loadByteW),
    .byteOffsetW(byteOffsetW), .flagsW(flagsW)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;   // 100 ns period
  end

  // ========================================
  // Failure reporting and compare tasks
  // ========================================
  task automatic stopOnFailure();
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped after the first failure");
  endtask

  task automatic checkBit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("[ERROR] %s expected 0x%h actual 0x%h", name, expected, actual);
      stopOnFailure();
    end
  endtask

  task automatic checkAluOp(input string name, input armIsaPkg::aluOp_e actual,
                            input armIsaPkg::aluOp_e expected);
    if (actual !== expected) begin
      $display("[ERROR] %s expected 0x%h actual 0x%h", name, expected, actual);
      stopOnFailure();
    end
  endtask

  task automatic checkFlags(input string name, input armIsaPkg::nzcv_t actual,
                            input armIsaPkg::nzcv_t expected);
    if (actual !== expected) begin
      $display("[ERROR] %s expected 0x%h actual 0x%h", name, expected, actual);
      stopOnFailure();
    end
  endtask

  task automatic checkMask(input string name, input armPipePkg::byteMask_t actual,
                           input armPipePkg::byteMask_t expected);
    if (actual !== expected) begin
      $display("[ERROR] %s expected 0x%h actual 0x%h", name, expected, actual);
      stopOnFailure();
    end
  endtask

  task automatic checkImmSrc(input string name, input armPipePkg::immSrc_e actual,
                             input armPipePkg::immSrc_e expected);
    if (actual !== expected) begin
      $display("[ERROR] %s expected 0x%h actual 0x%h", name, expected, actual);
      stopOnFailure();
    end
  endtask

  // ========================================
  // Reference model
  // ========================================
  // Even codes test a flag term, odd codes invert it
  function automatic logic condHolds(input armIsaPkg::cond_e cond, input armIsaPkg::nzcv_t f);
    logic [3:0] c;
    logic       base;
    c = cond;
    case (c[3:1])
      3'd0:    base = f.z;
      3'd1:    base = f.c;
      3'd2:    base = f.n;
      3'd3:    base = f.v;
      3'd4:    base = f.c & ~f.z;
      3'd5:    base = (f.n == f.v);
      3'd6:    base = ~f.z & (f.n == f.v);
      default: base = 1'b1;   // AL always true and NV inverts it to 0
    endcase
    return c[0] ? ~base : base;
  endfunction

  task automatic decodeModel(input logic [`WORD_W-1:0] ins);
    logic [3:0] op;
    logic       load;
    op = ins[`OPC_MSB:`OPC_LSB];
    load = ins[`LOAD_BIT];
    {dAluSrc, dMemtoReg, dRegWrite, dMemWrite, dBranch, dByte} = '0;
    dAluOp     = armIsaPkg::opAdd;
    dFlagWrite = armIsaPkg::noFlags;
    dRegSrc    = 2'b00;
    dImmSrc    = armPipePkg::imm8Rot;
    dCond      = armIsaPkg::cond_e'(ins[`COND_MSB:`COND_LSB]);
    case (ins[`CLASS_MSB:`CLASS_LSB])
      2'b00: begin                                   // Data processing
        dAluSrc   = ins[`IMM_BIT];
        dRegWrite = (op[3:2] != 2'b10);              // 8..11 are compares
        dAluOp    = armIsaPkg::aluOp_e'(op);
        if (ins[`SBIT]) begin
          dFlagWrite = ((op >= 4'h2 && op <= 4'h7) || op == 4'hA || op == 4'hB) ?
                       armIsaPkg::allFlags : armIsaPkg::nzOnly;
        end
      end
      2'b01: begin                                   // Load or store
        dAluSrc   = 1'b1;
        dMemtoReg = load;
        dRegWrite = load;
        dMemWrite = ~load;
        dByte     = ins[`BYTE_BIT];
        dAluOp    = ins[`UP_BIT] ? armIsaPkg::opAdd : armIsaPkg::opSub;
        dImmSrc   = armPipePkg::imm12;
        dRegSrc   = {~load, 1'b0};
      end
      2'b10: begin                                   // Branch
        dAluSrc = 1'b1;
        dBranch = 1'b1;
        dImmSrc = armPipePkg::imm24;
        dRegSrc = 2'b01;
      end
      default: ;                                     // Undefined is a no-op
    endcase
    dPcSrc = dBranch | (dRegWrite & (ins[`RD_MSB:`RD_LSB] == 4'd15));
  endtask

  task automatic resetModel();
    mCondE = armIsaPkg::condNv;
    mFlagWriteE = armIsaPkg::noFlags;
    mAluOpE = armIsaPkg::opAnd;
    {mAluSrcE, mMemtoRegE, mRegWriteE, mMemWriteE, mBranchE, mPcSrcE, mByteE} = '0;
    {mMemWriteM, mMemtoRegM, mRegWriteM, mPcSrcM, mSetFlagsM, mByteM} = '0;
    {mFlagsNextM, mFlagsNextW, mFlags, mByteMaskM, mOffsetM, mOffsetW} = '0;
    {mRegWriteW, mMemtoRegW, mPcSrcW, mSetFlagsW, mLoadByteW} = '0;
  endtask

  function automatic armIsaPkg::nzcv_t fwdFlags();
    if (mSetFlagsM) return mFlagsNextM;   // Youngest setter wins
    if (mSetFlagsW) return mFlagsNextW;
    return mFlags;
  endfunction

  // Advance the model across the coming rising edge
  task automatic modelStep();
    armIsaPkg::nzcv_t      fwd, nxt;
    logic                  ex;
    armPipePkg::byteMask_t mask;
    fwd = fwdFlags();
    ex  = condHolds(mCondE, fwd);
    nxt = fwd;
    if (mFlagWriteE != armIsaPkg::noFlags) {nxt.n, nxt.z} = {aluFlagsE.n, aluFlagsE.z};
    if (mFlagWriteE == armIsaPkg::allFlags) {nxt.c, nxt.v} = {aluFlagsE.c, aluFlagsE.v};
    mask = '0;
    mask[addrLowE] = 1'b1;
    if (!mByteE) mask = 4'hF;   // Word access
    if (rst) begin
      resetModel();
    end else begin
      if (!stallW && mSetFlagsW) mFlags = mFlagsNextW;
      if (flushW) begin
        {mRegWriteW, mMemtoRegW, mPcSrcW, mSetFlagsW, mLoadByteW} = '0;
        {mFlagsNextW, mOffsetW} = '0;
      end else if (!stallW) begin
        {mRegWriteW, mMemtoRegW, mPcSrcW} = {mRegWriteM, mMemtoRegM, mPcSrcM};
        {mSetFlagsW, mFlagsNextW} = {mSetFlagsM, mFlagsNextM};
        {mLoadByteW, mOffsetW} = {mByteM, mOffsetM};
      end
      if (!stallM) begin                             // No flush in Memory
        mMemWriteM  = mMemWriteE & ex;
        mMemtoRegM  = mMemtoRegE;
        mRegWriteM  = mRegWriteE & ex;
        mPcSrcM     = mPcSrcE & ex;
        mSetFlagsM  = (mFlagWriteE != armIsaPkg::noFlags) & ex;
        mFlagsNextM = nxt;
        mByteMaskM  = mask;
        mByteM      = mByteE;
        mOffsetM    = addrLowE;
      end
      if (flushE) begin                              // Bubble never executes
        mCondE = armIsaPkg::condNv;
        mFlagWriteE = armIsaPkg::noFlags;
        mAluOpE = armIsaPkg::opAnd;
        {mAluSrcE, mMemtoRegE, mRegWriteE, mMemWriteE, mBranchE, mPcSrcE, mByteE} = '0;
      end else if (!stallE) begin
        mCondE      = dCond;
        mFlagWriteE = dFlagWrite;
        mAluOpE     = dAluOp;
        {mAluSrcE, mMemtoRegE} = {dAluSrc, dMemtoReg};
        {mRegWriteE, mMemWriteE} = {dRegWrite, dMemWrite};
        {mBranchE, mPcSrcE, mByteE} = {dBranch, dPcSrc, dByte};
      end
    end
  endtask

  // ========================================
  // Stimulus and checking
  // ========================================
  task automatic checkOutputs();
    checkBit("regSrcD[0]", regSrcD[0], dRegSrc[0]);
    checkBit("regSrcD[1]", regSrcD[1], dRegSrc[1]);
    checkImmSrc("immSrcD", immSrcD, dImmSrc);
    checkBit("aluSrcE", aluSrcE, mAluSrcE);
    checkAluOp("aluControlE", aluControlE, mAluOpE);
    checkBit("branchTakenE", branchTakenE, mBranchE & condHolds(mCondE, fwdFlags()));
    checkBit("memWriteM", memWriteM, mMemWriteM);
    checkBit("memtoRegM", memtoRegM, mMemtoRegM);
    checkBit("regWriteM", regWriteM, mRegWriteM);
    checkMask("byteMaskM", byteMaskM, mByteMaskM);
    checkBit("regWriteW", regWriteW, mRegWriteW);
    checkBit("memtoRegW", memtoRegW, mMemtoRegW);
    checkBit("pcSrcW", pcSrcW, mPcSrcW);
    checkBit("loadByteW", loadByteW, mLoadByteW);
    checkMask("byteOffsetW", 4'(byteOffsetW), 4'(mOffsetW));
    checkFlags("flagsW", flagsW, mFlags);
  endtask

  task automatic driveRandom();
    logic [31:0] word;
    logic [31:0] rnd;
    int          pick;
    word = $random(seed);
    pick = $unsigned($random(seed)) % 16;
    if (pick == 0) word[`CLASS_MSB:`CLASS_LSB] = 2'b11;   // Rare undefined class
    else word[`CLASS_MSB:`CLASS_LSB] = 2'(pick % 3);
    instrD = word;
    rnd = $random(seed);
    aluFlagsE = rnd[3:0];
    addrLowE  = rnd[5:4];
    stallE = ($unsigned($random(seed)) % 10) == 0;   // About 10 %
    stallM = ($unsigned($random(seed)) % 10) == 0;
    stallW = ($unsigned($random(seed)) % 10) == 0;
    flushE = ($unsigned($random(seed)) % 20) == 0;   // About 5 %
    flushW = ($unsigned($random(seed)) % 20) == 0;
    decodeModel(instrD);
  endtask

  task automatic driveQuiet();
    instrD = `NOP_INSTR;
    {stallE, stallM, stallW, flushE, flushW} = '0;
    decodeModel(instrD);
  endtask

  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleCount >= CycleLimit) begin
      $display("Timeout: the run went past %0d clock cycles", CycleLimit);
      stopOnFailure();
    end
  end

  initial begin
    rst = 1'b1;
    aluFlagsE = '0;
    addrLowE = 2'b00;
    driveQuiet();
    resetModel();
    repeat (2) @(posedge clk);                       // Two rising edges in reset
    @(negedge clk);
    rst = 1'b0;
    checkOutputs();                                  // Reset values
    for (int i = 0; i < NumInstr; i++) begin
      if (i > 0) begin
        @(negedge clk);
        checkOutputs();
      end
      driveRandom();
      modelStep();
    end
    repeat (4) begin                                 // Drain the pipeline
      @(negedge clk);
      checkOutputs();
      driveQuiet();
      modelStep();
    end
    @(negedge clk);
    checkOutputs();
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+.
armIsaPkg.sv
armPipePkg.sv
instrDecoder.sv
condUnit.sv
statusFlags.sv
pipeCtrl.sv
armController.sv
tbArmController.sv

// ==== Bender.yml ====
package:
  name: armController

export_include_dirs:
  - .

sources:
  - armIsaPkg.sv
  - armPipePkg.sv
  - instrDecoder.sv
  - condUnit.sv
  - statusFlags.sv
  - pipeCtrl.sv
  - armController.sv
  - target: test
    files:
      - tbArmController.sv
